//--- verilog/ctrl_bypass_pkg.sv
`default_nettype none

// Shared types for the ID/EX/WB hazard and bypass controller
package ctrl_bypass_pkg;

  ////////////////////////////////////////////////////////////
  // Address widths
  ////////////////////////////////////////////////////////////

  // Integer register file address, x0..x31
  typedef logic [4:0] rf_addr_t;

  // CSR address space
  typedef logic [11:0] csr_addr_t;

  ////////////////////////////////////////////////////////////
  // Forward mux selects
  ////////////////////////////////////////////////////////////

  // Operand forward source for one ID read port
  // Encoding matches the operand mux in the ID stage
  typedef enum logic [1:0] {
    FW_REGFILE = 2'b00,
    FW_EX      = 2'b01,
    FW_WB      = 2'b10
  } fw_sel_e;

  // Jump-register forward source for the PC target adder
  // Only WB can feed it, EX results stall instead
  typedef enum logic {
    JSEL_REGFILE = 1'b0,
    JSEL_FW_WB   = 1'b1
  } jalr_sel_e;

endpackage

`default_nettype wire

//--- verilog/id_instr_qualify.sv
`timescale 1ns/10ps
`default_nettype none

// Qualifies the ID-stage instruction flags used by the hazard units
module id_instr_qualify (
  // Instruction in ID is valid
  input  wire logic id_valid_i,
  // Raw decoder flags
  input  wire logic id_jalr_i,
  input  wire logic id_mret_i,
  // Fetch-side faults and debug match
  input  wire logic id_bus_err_i,
  input  wire logic id_access_fault_i,
  input  wire logic id_trigger_i,
  // Qualified flags
  output logic      id_jalr_o,
  output logic      id_mret_o,
  // Kill write enables of the ID instruction
  output logic      deassert_we_o
);

  // Flags are gated with validity only
  // Decoder enables are not used, so a flag may be set for an instruction
  // that is turned into a nop, which at worst costs a stall cycle
  // A hazard is never missed this way
  assign id_jalr_o = id_jalr_i && id_valid_i;

  // mret reads mepc and mcause implicitly while in ID
  assign id_mret_o = id_mret_i && id_valid_i;

  ////////////////////////////////////////////////////////////
  // Write-enable deassert
  ////////////////////////////////////////////////////////////

  // Faulting fetch becomes a nop that travels down to WB
  // Trigger match also blocks writes, the instruction must not
  // execute before debug entry
  always_comb begin
    deassert_we_o = 1'b0;
    if (id_bus_err_i || id_access_fault_i || id_trigger_i) begin
      deassert_we_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rf_addr_compare.sv
`timescale 1ns/10ps
`default_nettype none

// Compares ID read addresses with the EX and WB write addresses
module rf_addr_compare import ctrl_bypass_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // ID read requests
  input  wire logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  wire rf_addr_t                  rf_raddr_id_i [NUM_READ_PORTS],
  // EX pipeline register
  input  wire logic                      ex_valid_i,
  input  wire logic                      ex_rf_we_i,
  input  wire rf_addr_t                  ex_rf_waddr_i,
  // WB pipeline register
  input  wire logic                      wb_valid_i,
  input  wire logic                      wb_rf_we_i,
  input  wire rf_addr_t                  wb_rf_waddr_i,
  // Qualified hits per read port
  output logic [NUM_READ_PORTS-1:0]      ex_hit_o,
  output logic [NUM_READ_PORTS-1:0]      wb_hit_o,
  // rs1 hits for the jump-register path
  output logic                           jalr_ex_hit_o,
  output logic                           jalr_wb_hit_o
);

  // Stage actually writes the register file
  logic ex_writes;
  logic wb_writes;

  // Only place where write validity is tested
  assign ex_writes = ex_valid_i && ex_rf_we_i;
  assign wb_writes = wb_valid_i && wb_rf_we_i;

  ////////////////////////////////////////////////////////////
  // Per-port match
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_port_hit
    // x0 is hardwired to zero and never forwarded
    assign ex_hit_o[i] = rf_re_id_i[i] && (|rf_raddr_id_i[i]) &&
                         (rf_raddr_id_i[i] == ex_rf_waddr_i) && ex_writes;
    assign wb_hit_o[i] = rf_re_id_i[i] && (|rf_raddr_id_i[i]) &&
                         (rf_raddr_id_i[i] == wb_rf_waddr_i) && wb_writes;
  end

  // JALR implies a read of rs1 on port 0
  // Read enable left out, the jalr flag qualifies these downstream
  assign jalr_ex_hit_o = (|rf_raddr_id_i[0]) && (rf_raddr_id_i[0] == ex_rf_waddr_i) &&
                         ex_writes;
  assign jalr_wb_hit_o = (|rf_raddr_id_i[0]) && (rf_raddr_id_i[0] == wb_rf_waddr_i) &&
                         wb_writes;

endmodule

`default_nettype wire

//--- verilog/operand_fwd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// Forward source selection for the ID operand and jump-register muxes
module operand_fwd_ctrl import ctrl_bypass_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // Qualified hits per read port
  input  wire logic [NUM_READ_PORTS-1:0] ex_hit_i,
  input  wire logic [NUM_READ_PORTS-1:0] wb_hit_i,
  // rs1 hit against WB for the jump target
  input  wire logic                      jalr_wb_hit_i,
  // Mux selects
  output fw_sel_e                        operand_fw_sel_o [NUM_READ_PORTS],
  output jalr_sel_e                      jalr_fw_sel_o
);

  ////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////

  // EX holds the younger result, so it wins over WB
  // EX value of a load is not ready yet, load stall covers that case
  always_comb begin
    for (int i = 0; i < NUM_READ_PORTS; i++) begin
      if (ex_hit_i[i]) begin
        operand_fw_sel_o[i] = FW_EX;
      end else if (wb_hit_i[i]) begin
        operand_fw_sel_o[i] = FW_WB;
      end else begin
        operand_fw_sel_o[i] = FW_REGFILE;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Jump-register forwarding
  ////////////////////////////////////////////////////////////

  // WB only, and only useful for ALU results
  // Load results in WB stall the jalr instead, too late for the PC path
  // Not gated with jalr in ID, the select is a don't care then
  always_comb begin
    jalr_fw_sel_o = JSEL_REGFILE;
    if (jalr_wb_hit_i) begin
      jalr_fw_sel_o = JSEL_FW_WB;
    end
  end

endmodule

`default_nettype wire

//--- verilog/gpr_hazard_stall.sv
`timescale 1ns/10ps
`default_nettype none

// Load-use and jump-register stalls for the ID stage
module gpr_hazard_stall #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // Qualified hits per read port
  input  wire logic [NUM_READ_PORTS-1:0] ex_hit_i,
  input  wire logic [NUM_READ_PORTS-1:0] wb_hit_i,
  // rs1 hits for the jump-register path
  input  wire logic                      jalr_ex_hit_i,
  input  wire logic                      jalr_wb_hit_i,
  // Load or store in EX and WB
  input  wire logic                      ex_lsu_en_i,
  input  wire logic                      wb_lsu_en_i,
  // WB done with its data, low during a bus wait state
  input  wire logic                      wb_ready_i,
  // Qualified jalr in ID
  input  wire logic                      id_jalr_i,
  // Stalls
  output logic                           load_stall_o,
  output logic                           jalr_stall_o
);

  // Any port hitting each stage
  logic any_ex_hit;
  logic any_wb_hit;
  // Individual stall causes
  logic load_use_ex;
  logic load_use_wb;
  logic jalr_hz_ex;
  logic jalr_hz_wb;

  assign any_ex_hit = |ex_hit_i;
  assign any_wb_hit = |wb_hit_i;

  ////////////////////////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////////////////////////

  // Load data for EX shows up a cycle later in WB
  assign load_use_ex = any_ex_hit && ex_lsu_en_i;

  // WB result not there yet while the bus is waiting
  assign load_use_wb = any_wb_hit && !wb_ready_i;

  assign load_stall_o = load_use_ex || load_use_wb;

  ////////////////////////////////////////////////////////////
  // Jump-register stall
  ////////////////////////////////////////////////////////////

  // No EX to PC forward path at all
  assign jalr_hz_ex = jalr_ex_hit_i;

  // WB forward only covers ALU results
  // Load data would sit on a long timing path into the PC adder
  assign jalr_hz_wb = jalr_wb_hit_i && wb_lsu_en_i;

  // ID is held anyway, so nothing to deassert there
  assign jalr_stall_o = id_jalr_i && (jalr_hz_ex || jalr_hz_wb);

endmodule

`default_nettype wire

//--- verilog/csr_hazard_detect.sv
`timescale 1ns/10ps
`default_nettype none

// CSR read-after-write hazard detection for the ID and EX stages
module csr_hazard_detect import ctrl_bypass_pkg::*; (
  // Qualified mret in ID
  input  wire logic      id_mret_i,
  // EX pipeline register
  input  wire logic      ex_valid_i,
  input  wire logic      ex_csr_en_i,
  input  wire logic      ex_mret_i,
  input  wire logic      ex_csr_impl_wr_i,
  input  wire logic      ex_csr_impl_re_i,
  input  wire logic      ex_csr_expl_re_i,
  input  wire csr_addr_t ex_csr_raddr_i,
  // WB pipeline register
  input  wire logic      wb_valid_i,
  input  wire logic      wb_csr_en_i,
  input  wire logic      wb_mret_i,
  input  wire logic      wb_csr_impl_wr_i,
  input  wire logic      wb_csr_expl_we_i,
  input  wire csr_addr_t wb_csr_waddr_i,
  // Stalls
  output logic           csr_stall_id_o,
  output logic           csr_stall_ex_o
);

  // Implicit writes per stage
  logic ex_impl_wr;
  logic wb_impl_wr;
  // Implicit or explicit writes per stage
  logic ex_csr_wr;
  logic wb_csr_wr;
  // Exact explicit RAW between EX and WB
  logic expl_raw_ex;

  ////////////////////////////////////////////////////////////
  // Write detection
  ////////////////////////////////////////////////////////////

  // mret updates mstatus implicitly
  // Some CSR instructions also write a second CSR, flagged by impl_wr
  assign ex_impl_wr = ex_valid_i && (ex_mret_i || (ex_csr_en_i && ex_csr_impl_wr_i));
  assign wb_impl_wr = wb_valid_i && (wb_mret_i || (wb_csr_en_i && wb_csr_impl_wr_i));

  // Any CSR instruction counts as a writer here
  assign ex_csr_wr = ex_valid_i && (ex_csr_en_i || ex_impl_wr);
  assign wb_csr_wr = wb_valid_i && (wb_csr_en_i || wb_impl_wr);

  // Only hazard with a precise address compare
  assign expl_raw_ex = ex_csr_expl_re_i && wb_csr_expl_we_i &&
                       (ex_csr_raddr_i == wb_csr_waddr_i);

  ////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////

  // mret in ID reads mepc and mcause
  // Conservative, any write in EX or WB holds it
  always_comb begin
    csr_stall_id_o = 1'b0;
    if (id_mret_i && (ex_csr_wr || wb_csr_wr)) begin
      csr_stall_id_o = 1'b1;
    end
  end

  // EX stalls on
  //   implicit read against any write in WB
  //   CSR instruction against an implicit write in WB
  //   explicit read against an explicit write to the same CSR
  always_comb begin
    csr_stall_ex_o = 1'b0;
    if (ex_csr_impl_re_i && wb_csr_wr) begin
      csr_stall_ex_o = 1'b1;
    end
    if (ex_valid_i && ex_csr_en_i && wb_impl_wr) begin
      csr_stall_ex_o = 1'b1;
    end
    if (expl_raw_ex) begin
      csr_stall_ex_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ctrl_bypass.sv
`timescale 1ns/10ps
`default_nettype none

// Hazard and bypass controller for the ID/EX/WB issue path
module ctrl_bypass import ctrl_bypass_pkg::*; #(
  parameter int unsigned NUM_READ_PORTS = 2
) (
  // ID read requests, port 0 is rs1
  input  wire logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  wire rf_addr_t                  rf_raddr_id_i [NUM_READ_PORTS],
  // ID instruction
  input  wire logic                      id_valid_i,
  input  wire logic                      id_jalr_i,
  input  wire logic                      id_mret_i,
  input  wire logic                      id_bus_err_i,
  input  wire logic                      id_access_fault_i,
  input  wire logic                      id_trigger_i,
  // EX pipeline register
  input  wire logic                      ex_valid_i,
  input  wire logic                      ex_rf_we_i,
  input  wire rf_addr_t                  ex_rf_waddr_i,
  input  wire logic                      ex_lsu_en_i,
  input  wire logic                      ex_csr_en_i,
  input  wire logic                      ex_mret_i,
  input  wire logic                      ex_csr_impl_wr_i,
  input  wire logic                      ex_csr_impl_re_i,
  input  wire logic                      ex_csr_expl_re_i,
  input  wire csr_addr_t                 ex_csr_raddr_i,
  // WB pipeline register
  input  wire logic                      wb_valid_i,
  input  wire logic                      wb_rf_we_i,
  input  wire rf_addr_t                  wb_rf_waddr_i,
  input  wire logic                      wb_lsu_en_i,
  input  wire logic                      wb_csr_en_i,
  input  wire logic                      wb_mret_i,
  input  wire logic                      wb_csr_impl_wr_i,
  input  wire logic                      wb_csr_expl_we_i,
  input  wire csr_addr_t                 wb_csr_waddr_i,
  input  wire logic                      wb_ready_i,
  // Forward selects
  output fw_sel_e                        operand_fw_sel_o [NUM_READ_PORTS],
  output jalr_sel_e                      jalr_fw_sel_o,
  // Stalls and write kill
  output logic                           load_stall_o,
  output logic                           jalr_stall_o,
  output logic                           csr_stall_id_o,
  output logic                           csr_stall_ex_o,
  output logic                           deassert_we_o
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  // Qualified ID flags
  logic                      id_jalr_q;
  logic                      id_mret_q;
  // Qualified register hits
  logic [NUM_READ_PORTS-1:0] ex_hit;
  logic [NUM_READ_PORTS-1:0] wb_hit;
  logic                      jalr_ex_hit;
  logic                      jalr_wb_hit;

  id_instr_qualify u_id_instr_qualify (
    .id_valid_i        (id_valid_i),
    .id_jalr_i         (id_jalr_i),
    .id_mret_i         (id_mret_i),
    .id_bus_err_i      (id_bus_err_i),
    .id_access_fault_i (id_access_fault_i),
    .id_trigger_i      (id_trigger_i),
    .id_jalr_o         (id_jalr_q),
    .id_mret_o         (id_mret_q),
    .deassert_we_o     (deassert_we_o)
  );

  rf_addr_compare #(
    .NUM_READ_PORTS (NUM_READ_PORTS)
  ) u_rf_addr_compare (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id_i),
    .ex_valid_i    (ex_valid_i),
    .ex_rf_we_i    (ex_rf_we_i),
    .ex_rf_waddr_i (ex_rf_waddr_i),
    .wb_valid_i    (wb_valid_i),
    .wb_rf_we_i    (wb_rf_we_i),
    .wb_rf_waddr_i (wb_rf_waddr_i),
    .ex_hit_o      (ex_hit),
    .wb_hit_o      (wb_hit),
    .jalr_ex_hit_o (jalr_ex_hit),
    .jalr_wb_hit_o (jalr_wb_hit)
  );

  operand_fwd_ctrl #(
    .NUM_READ_PORTS (NUM_READ_PORTS)
  ) u_operand_fwd_ctrl (
    .ex_hit_i         (ex_hit),
    .wb_hit_i         (wb_hit),
    .jalr_wb_hit_i    (jalr_wb_hit),
    .operand_fw_sel_o (operand_fw_sel_o),
    .jalr_fw_sel_o    (jalr_fw_sel_o)
  );

  gpr_hazard_stall #(
    .NUM_READ_PORTS (NUM_READ_PORTS)
  ) u_gpr_hazard_stall (
    .ex_hit_i      (ex_hit),
    .wb_hit_i      (wb_hit),
    .jalr_ex_hit_i (jalr_ex_hit),
    .jalr_wb_hit_i (jalr_wb_hit),
    .ex_lsu_en_i   (ex_lsu_en_i),
    .wb_lsu_en_i   (wb_lsu_en_i),
    .wb_ready_i    (wb_ready_i),
    .id_jalr_i     (id_jalr_q),
    .load_stall_o  (load_stall_o),
    .jalr_stall_o  (jalr_stall_o)
  );

  csr_hazard_detect u_csr_hazard_detect (
    .id_mret_i        (id_mret_q),
    .ex_valid_i       (ex_valid_i),
    .ex_csr_en_i      (ex_csr_en_i),
    .ex_mret_i        (ex_mret_i),
    .ex_csr_impl_wr_i (ex_csr_impl_wr_i),
    .ex_csr_impl_re_i (ex_csr_impl_re_i),
    .ex_csr_expl_re_i (ex_csr_expl_re_i),
    .ex_csr_raddr_i   (ex_csr_raddr_i),
    .wb_valid_i       (wb_valid_i),
    .wb_csr_en_i      (wb_csr_en_i),
    .wb_mret_i        (wb_mret_i),
    .wb_csr_impl_wr_i (wb_csr_impl_wr_i),
    .wb_csr_expl_we_i (wb_csr_expl_we_i),
    .wb_csr_waddr_i   (wb_csr_waddr_i),
    .csr_stall_id_o   (csr_stall_id_o),
    .csr_stall_ex_o   (csr_stall_ex_o)
  );

endmodule

`default_nettype wire

//--- test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns are re, raddr0, raddr1, id flags, ex flags, ex_waddr, ex_csr_raddr,
// wb flags, wb_waddr, wb_csr_waddr, then expected sel0, sel1, jalr sel, stalls

////////////////////////////////////////////////////////////
// Row layout
////////////////////////////////////////////////////////////

typedef struct packed {
  logic [1:0] re;         // Read enables, bit 0 is rs1
  rf_addr_t   raddr0;
  rf_addr_t   raddr1;
  logic [5:0] id_f;       // valid jalr mret bus_err access_fault trigger
  logic [7:0] ex_f;       // valid rf_we lsu csr_en mret impl_wr impl_re expl_re
  rf_addr_t   ex_waddr;
  csr_addr_t  ex_craddr;
  logic [7:0] wb_f;       // valid rf_we lsu csr_en mret impl_wr expl_we ready
  rf_addr_t   wb_waddr;
  csr_addr_t  wb_cwaddr;
  fw_sel_e    sel0;
  fw_sel_e    sel1;
  jalr_sel_e  jsel;
  logic [4:0] stall;      // load jalr csr_id csr_ex deassert_we
} vec_t;

localparam int NUM_ROWS = 27;

vec_t vec_tbl [NUM_ROWS];

task automatic load_vectors();
  // Operand forwarding
  vec_tbl[0]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b00000000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  vec_tbl[1]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b00000000, 5'd0, 12'h000,
                  8'b11000001, 5'd3, 12'h000, FW_WB, FW_REGFILE, JSEL_FW_WB, 5'b00000};
  vec_tbl[2]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b11000000, 5'd4, 12'h000,
                  8'b11000001, 5'd4, 12'h000, FW_REGFILE, FW_EX, JSEL_REGFILE, 5'b00000};
  // x0 on rs1 with both stages writing x0
  vec_tbl[3]  = '{2'b11, 5'd0, 5'd4, 6'b000000, 8'b11000000, 5'd0, 12'h000,
                  8'b11000000, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  // Port 0 disabled against a load in EX
  vec_tbl[4]  = '{2'b10, 5'd3, 5'd4, 6'b000000, 8'b11100000, 5'd3, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  vec_tbl[5]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b01000000, 5'd3, 12'h000,
                  8'b01000000, 5'd4, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  vec_tbl[6]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b10100000, 5'd3, 12'h000,
                  8'b10000000, 5'd4, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  // Load-use
  vec_tbl[7]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b11100000, 5'd4, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_EX, JSEL_REGFILE, 5'b10000};
  vec_tbl[8]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b11000000, 5'd4, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_EX, JSEL_REGFILE, 5'b00000};
  vec_tbl[9]  = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b00000000, 5'd0, 12'h000,
                  8'b11000000, 5'd3, 12'h000, FW_WB, FW_REGFILE, JSEL_FW_WB, 5'b10000};
  // Jump-register path
  vec_tbl[10] = '{2'b01, 5'd3, 5'd4, 6'b110000, 8'b11000000, 5'd3, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_EX, FW_REGFILE, JSEL_REGFILE, 5'b01000};
  vec_tbl[11] = '{2'b01, 5'd3, 5'd4, 6'b110000, 8'b00000000, 5'd0, 12'h000,
                  8'b11100001, 5'd3, 12'h000, FW_WB, FW_REGFILE, JSEL_FW_WB, 5'b01000};
  vec_tbl[12] = '{2'b01, 5'd3, 5'd4, 6'b110000, 8'b00000000, 5'd0, 12'h000,
                  8'b11000001, 5'd3, 12'h000, FW_WB, FW_REGFILE, JSEL_FW_WB, 5'b00000};
  vec_tbl[13] = '{2'b01, 5'd3, 5'd4, 6'b100000, 8'b00000000, 5'd0, 12'h000,
                  8'b11100001, 5'd3, 12'h000, FW_WB, FW_REGFILE, JSEL_FW_WB, 5'b00000};
  vec_tbl[14] = '{2'b01, 5'd3, 5'd4, 6'b010000, 8'b11000000, 5'd3, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_EX, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  // mret in ID
  vec_tbl[15] = '{2'b11, 5'd3, 5'd4, 6'b101000, 8'b10010000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00100};
  vec_tbl[16] = '{2'b11, 5'd3, 5'd4, 6'b101000, 8'b00000000, 5'd0, 12'h000,
                  8'b10010001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00100};
  vec_tbl[17] = '{2'b11, 5'd3, 5'd4, 6'b101000, 8'b10001000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00100};
  vec_tbl[18] = '{2'b11, 5'd3, 5'd4, 6'b101000, 8'b00000000, 5'd0, 12'h000,
                  8'b10001001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00100};
  vec_tbl[19] = '{2'b11, 5'd3, 5'd4, 6'b001000, 8'b10010000, 5'd0, 12'h000,
                  8'b10010001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  // CSR hazards in EX
  vec_tbl[20] = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b10010001, 5'd0, 12'h300,
                  8'b10010011, 5'd0, 12'h300, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00010};
  vec_tbl[21] = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b10010001, 5'd0, 12'h300,
                  8'b10010011, 5'd0, 12'h341, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00000};
  vec_tbl[22] = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b10000010, 5'd0, 12'h000,
                  8'b10010001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00010};
  vec_tbl[23] = '{2'b11, 5'd3, 5'd4, 6'b000000, 8'b10010000, 5'd0, 12'h000,
                  8'b10010101, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00010};
  // Faults and trigger, one at a time
  vec_tbl[24] = '{2'b11, 5'd3, 5'd4, 6'b100100, 8'b00000000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00001};
  vec_tbl[25] = '{2'b11, 5'd3, 5'd4, 6'b100010, 8'b00000000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00001};
  vec_tbl[26] = '{2'b11, 5'd3, 5'd4, 6'b100001, 8'b00000000, 5'd0, 12'h000,
                  8'b00000001, 5'd0, 12'h000, FW_REGFILE, FW_REGFILE, JSEL_REGFILE, 5'b00001};
endtask

`endif

//--- test/tb_ctrl_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ctrl_bypass import ctrl_bypass_pkg::*;;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 2;
  localparam int NUM_PORTS  = 2;
  localparam int NUM_RAND   = 40;

  logic clk;
  logic rst_i;
  integer seed;
  int errors;

  // DUT ports, named as on the DUT
  logic [NUM_PORTS-1:0] rf_re_id_i;
  rf_addr_t rf_raddr_id_i [NUM_PORTS];
  logic id_valid_i, id_jalr_i, id_mret_i;
  logic id_bus_err_i, id_access_fault_i, id_trigger_i;
  logic ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i;
  logic ex_csr_impl_wr_i, ex_csr_impl_re_i, ex_csr_expl_re_i;
  rf_addr_t ex_rf_waddr_i;
  csr_addr_t ex_csr_raddr_i;
  logic wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_csr_en_i, wb_mret_i;
  logic wb_csr_impl_wr_i, wb_csr_expl_we_i, wb_ready_i;
  rf_addr_t wb_rf_waddr_i;
  csr_addr_t wb_csr_waddr_i;
  fw_sel_e operand_fw_sel_o [NUM_PORTS];
  jalr_sel_e jalr_fw_sel_o;
  logic load_stall_o, jalr_stall_o, csr_stall_id_o, csr_stall_ex_o, deassert_we_o;

  `include "tb_vectors.svh"

  ctrl_bypass #(.NUM_READ_PORTS(NUM_PORTS)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reset phase, released on a falling edge
  initial begin
    rst_i = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic drive_inputs(input vec_t r);
    rf_re_id_i       = r.re;
    rf_raddr_id_i[0] = r.raddr0;
    rf_raddr_id_i[1] = r.raddr1;
    {id_valid_i, id_jalr_i, id_mret_i, id_bus_err_i, id_access_fault_i, id_trigger_i} = r.id_f;
    {ex_valid_i, ex_rf_we_i, ex_lsu_en_i, ex_csr_en_i, ex_mret_i, ex_csr_impl_wr_i,
     ex_csr_impl_re_i, ex_csr_expl_re_i} = r.ex_f;
    ex_rf_waddr_i  = r.ex_waddr;
    ex_csr_raddr_i = r.ex_craddr;
    {wb_valid_i, wb_rf_we_i, wb_lsu_en_i, wb_csr_en_i, wb_mret_i, wb_csr_impl_wr_i,
     wb_csr_expl_we_i, wb_ready_i} = r.wb_f;
    wb_rf_waddr_i  = r.wb_waddr;
    wb_csr_waddr_i = r.wb_cwaddr;
  endtask

  task automatic report_mismatch(input string name, input logic [11:0] exp,
                                 input logic [11:0] act);
    $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
    errors++;
  endtask

  // Random rows only carry valid selects and load stall
  task automatic check_outputs(input vec_t r, input bit full);
    if (operand_fw_sel_o[0] !== r.sel0)
      report_mismatch("operand_fw_sel_o[0]", r.sel0, operand_fw_sel_o[0]);
    if (operand_fw_sel_o[1] !== r.sel1)
      report_mismatch("operand_fw_sel_o[1]", r.sel1, operand_fw_sel_o[1]);
    if (load_stall_o !== r.stall[4])
      report_mismatch("load_stall_o", r.stall[4], load_stall_o);
    if (full) begin
      if (jalr_fw_sel_o !== r.jsel)
        report_mismatch("jalr_fw_sel_o", r.jsel, jalr_fw_sel_o);
      if (jalr_stall_o !== r.stall[3])
        report_mismatch("jalr_stall_o", r.stall[3], jalr_stall_o);
      if (csr_stall_id_o !== r.stall[2])
        report_mismatch("csr_stall_id_o", r.stall[2], csr_stall_id_o);
      if (csr_stall_ex_o !== r.stall[1])
        report_mismatch("csr_stall_ex_o", r.stall[1], csr_stall_ex_o);
      if (deassert_we_o !== r.stall[0])
        report_mismatch("deassert_we_o", r.stall[0], deassert_we_o);
    end
  endtask

  // Port forwards when enabled, non-zero, matching, and the stage writes
  function automatic logic port_hit(input logic en, input rf_addr_t ra, input rf_addr_t wa,
                                    input logic valid, input logic we);
    return en && (ra != 5'd0) && (ra == wa) && valid && we;
  endfunction

  // Younger EX result has priority
  function automatic fw_sel_e fwd_source(input logic ex_h, input logic wb_h);
    if (ex_h)
      return FW_EX;
    if (wb_h)
      return FW_WB;
    return FW_REGFILE;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    vec_t row;
    logic [31:0] rnd_f;
    logic [31:0] rnd_a;
    logic [1:0] exh;
    logic [1:0] wbh;
    errors = 0;
    seed   = 61;
    row    = '0;
    drive_inputs(row);
    load_vectors();
    // Inputs stay idle until reset is released
    wait (rst_i === 1'b0);

    // Directed table
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(negedge clk);
      drive_inputs(vec_tbl[i]);
      #(CLK_PERIOD / 2 - 1);
      check_outputs(vec_tbl[i], 1'b1);
    end

    // Random rows on a small address range so matches are frequent
    for (int k = 0; k < NUM_RAND; k++) begin
      rnd_f = $random(seed);
      rnd_a = $random(seed);
      row = '0;
      row.re        = rnd_f[1:0];
      row.id_f      = rnd_f[7:2];
      row.ex_f      = rnd_f[15:8];
      row.wb_f      = rnd_f[23:16];
      row.raddr0    = {3'b000, rnd_a[1:0]};
      row.raddr1    = {3'b000, rnd_a[3:2]};
      row.ex_waddr  = {3'b000, rnd_a[5:4]};
      row.wb_waddr  = {3'b000, rnd_a[7:6]};
      row.ex_craddr = rnd_a[19:8];
      row.wb_cwaddr = rnd_a[31:20];
      exh[0] = port_hit(row.re[0], row.raddr0, row.ex_waddr, row.ex_f[7], row.ex_f[6]);
      exh[1] = port_hit(row.re[1], row.raddr1, row.ex_waddr, row.ex_f[7], row.ex_f[6]);
      wbh[0] = port_hit(row.re[0], row.raddr0, row.wb_waddr, row.wb_f[7], row.wb_f[6]);
      wbh[1] = port_hit(row.re[1], row.raddr1, row.wb_waddr, row.wb_f[7], row.wb_f[6]);
      row.sel0     = fwd_source(exh[0], wbh[0]);
      row.sel1     = fwd_source(exh[1], wbh[1]);
      // Load in EX, or WB still waiting on the bus
      row.stall[4] = ((|exh) && row.ex_f[5]) || ((|wbh) && !row.wb_f[0]);
      @(negedge clk);
      drive_inputs(row);
      #(CLK_PERIOD / 2 - 1);
      check_outputs(row, 1'b0);
    end

    $display("Checked %0d directed and %0d random rows, %0d errors",
             NUM_ROWS, NUM_RAND, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the row count with some margin
  initial begin
    #((NUM_ROWS + NUM_RAND + 10) * CLK_PERIOD);
    $display("Timeout, the test did not finish within the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
verilog/ctrl_bypass_pkg.sv
verilog/id_instr_qualify.sv
verilog/rf_addr_compare.sv
verilog/operand_fwd_ctrl.sv
verilog/gpr_hazard_stall.sv
verilog/csr_hazard_detect.sv
verilog/ctrl_bypass.sv
test/tb_ctrl_bypass.sv

//--- Bender.yml
package:
  name: ctrl_bypass

sources:
  - verilog/ctrl_bypass_pkg.sv
  - verilog/id_instr_qualify.sv
  - verilog/rf_addr_compare.sv
  - verilog/operand_fwd_ctrl.sv
  - verilog/gpr_hazard_stall.sv
  - verilog/csr_hazard_detect.sv
  - verilog/ctrl_bypass.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ctrl_bypass.sv
